// ==== src/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int ADDR_W = 11; // 2048 byte array
    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam int SCL_DIV = 4; // clk cycles per scl period

    // quarter phases of one scl period
    typedef enum logic [1:0] {
        PH_LOW0 = 2'd0, // scl low, sda may change here
        PH_RISE = 2'd1,
        PH_HIGH = 2'd2, // sample point
        PH_FALL = 2'd3
    } phase_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_WR,
        ST_ADDR,
        ST_DATA_WR,
        ST_RESTART, // repeated start before the read
        ST_CTRL_RD,
        ST_DATA_RD,
        ST_STOP,
        ST_DONE
    } main_state_t;

    // bus conditions made by bus_cond
    typedef enum logic {
        COND_START = 1'b0,
        COND_STOP  = 1'b1
    } cond_t;

endpackage

// ==== src/bus_cond.sv ====
module bus_cond import eeprom_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  phase_t phase,
    input  logic   start,
    input  cond_t  kind,
    output logic   sda_low,
    output logic   done
);

    logic  active;
    logic  drv;
    cond_t kind_q;

    assign sda_low = active & drv;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active <= 1'b0;
            drv    <= 1'b0;
            done   <= 1'b0;
            kind_q <= COND_START;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                kind_q <= kind;
                drv    <= (kind == COND_STOP); // stop begins from sda low
            end else if (active) begin
                case (phase)
                    PH_RISE: begin
                        // edge on sda while scl is high
                        drv  <= (kind_q == COND_START);
                        done <= 1'b1;
                    end
                    PH_FALL: begin
                        active <= 1'b0;
                        drv    <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        start |-> !active);

endmodule

// ==== src/byte_tx.sv ====
module byte_tx import eeprom_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  phase_t     phase,
    input  logic       start,
    input  logic [7:0] byte_in,
    output logic       sda_low,
    output logic       done
);

    logic       active;
    logic       drv;
    logic [7:0] sh;
    logic [3:0] bit_cnt; // bit periods finished

    assign sda_low = active & drv;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            drv     <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= 4'd0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active  <= 1'b1;
                drv     <= ~byte_in[7]; // msb shows up in PH_LOW0
                bit_cnt <= 4'd0;
            end else if (active && phase == PH_FALL) begin
                if (bit_cnt == 4'd8) begin
                    active <= 1'b0;
                    drv    <= 1'b0;
                end else begin
                    drv     <= ~sh[7];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (active && phase == PH_RISE && bit_cnt == 4'd8) begin
                done <= 1'b1; // slave ack bit clocked but ignored
            end
        end
    end

    // ones shift in behind the data so the ninth bit is released
    always_ff @(posedge CLK) begin
        if (start) begin
            sh <= {byte_in[6:0], 1'b1};
        end else if (active && phase == PH_FALL) begin
            sh <= {sh[6:0], 1'b1};
        end
    end

    a_done_active: assert property (@(posedge CLK) disable iff (RESET)
        done |-> active);

endmodule

// ==== src/byte_rx.sv ====
module byte_rx import eeprom_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  phase_t     phase,
    input  logic       start,
    input  logic       nack,
    input  logic       sda_in,
    output logic       sda_low,
    output logic [7:0] byte_out,
    output logic       done
);

    logic       active;
    logic       drv;
    logic       nack_q;
    logic [3:0] bit_cnt;

    assign sda_low = active & drv;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            drv     <= 1'b0;
            done    <= 1'b0;
            nack_q  <= 1'b0;
            bit_cnt <= 4'd0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active  <= 1'b1;
                drv     <= 1'b0; // slave owns sda for the data bits
                nack_q  <= nack;
                bit_cnt <= 4'd0;
            end else if (active && phase == PH_FALL) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd7) begin
                    drv <= ~nack_q; // master ack or nack
                end else if (bit_cnt == 4'd8) begin
                    active <= 1'b0;
                    drv    <= 1'b0;
                end
            end else if (active && phase == PH_RISE && bit_cnt == 4'd8) begin
                done <= 1'b1;
            end
        end
    end

    // sample mid scl high, msb first
    always_ff @(posedge CLK) begin
        if (active && phase == PH_HIGH && !bit_cnt[3]) begin
            byte_out <= {byte_out[6:0], sda_in};
        end
    end

endmodule

// ==== src/eeprom_ctrl.sv ====
module eeprom_ctrl import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    input  logic        sda_in,
    input  logic        cond_low,
    input  logic        cond_done,
    input  logic        tx_low,
    input  logic        tx_done,
    input  logic        rx_low,
    input  logic        rx_done,
    input  logic [7:0]  rx_byte,
    output logic        busy,
    output logic        ack,
    output logic [7:0]  rdata,
    output logic        scl,
    output logic        sda_low,
    output phase_t      phase,
    output logic        cond_start,
    output cond_t       cond_kind,
    output logic        tx_start,
    output logic [7:0]  tx_byte,
    output logic        rx_start,
    output logic        rx_nack
);

    main_state_t state;
    eeprom_req_t req_q;
    logic [1:0]  ph_cnt;

    assign phase   = phase_t'(ph_cnt);
    assign sda_low = cond_low | tx_low | rx_low; // idle engines never pull

    // phase counter parks on PH_FALL while idle
    always_ff @(posedge CLK) begin
        if (RESET || !busy || state == ST_DONE) begin
            ph_cnt <= 2'(SCL_DIV - 1);
            scl    <= 1'b1;
        end else begin
            ph_cnt <= (ph_cnt == 2'(SCL_DIV - 1)) ? 2'd0 : ph_cnt + 2'd1;
            // high in PH_RISE and PH_HIGH; stays high once the stop is out
            scl    <= (phase == PH_LOW0) || (phase == PH_RISE) ||
                      (state == ST_STOP && phase == PH_HIGH);
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state      <= ST_IDLE;
            req_q      <= '0;
            busy       <= 1'b0;
            ack        <= 1'b0;
            rdata      <= 8'h00;
            cond_start <= 1'b0;
            cond_kind  <= COND_START;
            tx_start   <= 1'b0;
            tx_byte    <= 8'h00;
            rx_start   <= 1'b0;
            rx_nack    <= 1'b0;
        end else begin
            ack        <= 1'b0;
            cond_start <= 1'b0;
            tx_start   <= 1'b0;
            rx_start   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr || rd) begin
                        req_q      <= req;
                        req_q.op   <= wr ? OP_WRITE : OP_READ; // write wins
                        busy       <= 1'b1;
                        cond_start <= 1'b1;
                        cond_kind  <= COND_START;
                        state      <= ST_START;
                    end
                end
                ST_START: begin
                    if (cond_done) begin
                        tx_start <= 1'b1;
                        tx_byte  <= {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b0};
                        state    <= ST_CTRL_WR;
                    end
                end
                ST_CTRL_WR: begin
                    if (tx_done) begin
                        tx_start <= 1'b1;
                        tx_byte  <= req_q.addr[7:0];
                        state    <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (tx_done && req_q.op == OP_WRITE) begin
                        tx_start <= 1'b1;
                        tx_byte  <= req_q.wdata;
                        state    <= ST_DATA_WR;
                    end else if (tx_done) begin
                        cond_start <= 1'b1;
                        cond_kind  <= COND_START;
                        state      <= ST_RESTART;
                    end
                end
                ST_RESTART: begin
                    if (cond_done) begin
                        tx_start <= 1'b1;
                        tx_byte  <= {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b1};
                        state    <= ST_CTRL_RD;
                    end
                end
                ST_CTRL_RD: begin
                    if (tx_done) begin
                        rx_start <= 1'b1;
                        rx_nack  <= 1'b1; // single byte, so it is also the last
                        state    <= ST_DATA_RD;
                    end
                end
                ST_DATA_WR, ST_DATA_RD: begin
                    if (tx_done || rx_done) begin
                        cond_start <= 1'b1;
                        cond_kind  <= COND_STOP;
                        state      <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (cond_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= ST_IDLE;
                    if (req_q.op == OP_READ) begin
                        rdata <= rx_byte;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack);

    // data bits and ack bits only move in the middle of scl low
    a_sda_low0: assert property (@(posedge CLK) disable iff (RESET)
        busy && !(state inside {ST_START, ST_RESTART, ST_STOP}) && $changed(sda_low)
        |-> phase == PH_LOW0);

    // line must be free once the stop is out
    a_bus_free: assert property (@(posedge CLK) disable iff (RESET)
        state == ST_DONE |-> sda_in);

endmodule

// ==== src/eeprom_if_top.sv ====
module eeprom_if_top import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  eeprom_req_t req,
    input  logic        sda_in,
    output logic        busy,
    output logic        ack,
    output logic [7:0]  rdata,
    output logic        scl,
    output logic        sda_low
);

    phase_t     phase;
    logic       cond_start;
    cond_t      cond_kind;
    logic       cond_low;
    logic       cond_done;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_low;
    logic       tx_done;
    logic       rx_start;
    logic       rx_nack;
    logic       rx_low;
    logic       rx_done;
    logic [7:0] rx_byte;

    // wire names match the controller ports
    eeprom_ctrl u_ctrl (.*);

    bus_cond u_cond (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .start   (cond_start),
        .kind    (cond_kind),
        .sda_low (cond_low),
        .done    (cond_done)
    );

    byte_tx u_tx (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .start   (tx_start),
        .byte_in (tx_byte),
        .sda_low (tx_low),
        .done    (tx_done)
    );

    byte_rx u_rx (
        .CLK      (CLK),
        .RESET    (RESET),
        .phase    (phase),
        .start    (rx_start),
        .nack     (rx_nack),
        .sda_in   (sda_in),
        .sda_low  (rx_low),
        .byte_out (rx_byte),
        .done     (rx_done)
    );

endmodule

// ==== dv/eeprom_model.sv ====
module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    logic [7:0]  mem [0:2047];
    logic [7:0]  last_ctrl;
    int          start_cnt;
    int          stop_cnt;
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        reading;
    logic        read_pending;
    logic        master_nack;
    logic [3:0]  cnt; // scl rises seen in this frame
    logic [1:0]  idx; // byte number since start
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [10:0] ptr;

    initial begin
        logic [10:0] a;
        for (int i = 0; i < 2048; i++) begin
            a = 11'(i);
            mem[i] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
        end
        sda_low      = 1'b0;
        last_ctrl    = 8'h00;
        start_cnt    = 0;
        stop_cnt     = 0;
        scl_q        = 1'b1;
        sda_q        = 1'b1;
        active       = 1'b0;
        reading      = 1'b0;
        read_pending = 1'b0;
        master_nack  = 1'b0;
        cnt          = 4'd0;
        idx          = 2'd0;
        sh           = 8'h00;
        tx           = 8'h00;
        ptr          = 11'd0;
    end

    // scl and sda never move in the same step, so one process sees every edge
    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            start_cnt++; // start or repeated start
            active       = 1'b1;
            reading      = 1'b0;
            read_pending = 1'b0;
            cnt          = 4'd0;
            idx          = 2'd0;
            sda_low      = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            stop_cnt++;
            active       = 1'b0;
            reading      = 1'b0;
            read_pending = 1'b0;
            sda_low      = 1'b0;
        end else if (scl_q === 1'b0 && scl === 1'b1 && active) begin
            if (cnt < 4'd8 && !reading) begin
                sh = {sh[6:0], sda};
            end
            if (cnt == 4'd8 && reading) begin
                master_nack = sda;
            end
            cnt = cnt + 4'd1;
        end else if (scl_q === 1'b1 && scl === 1'b0 && active) begin
            if (cnt == 4'd8) begin
                if (reading) begin
                    sda_low = 1'b0; // master answers now
                end else begin
                    case (idx)
                        2'd0: begin
                            last_ctrl    = sh;
                            ptr[10:8]    = sh[3:1];
                            read_pending = sh[0];
                        end
                        2'd1: ptr[7:0] = sh;
                        default: begin
                            mem[ptr] = sh;
                            ptr      = ptr + 11'd1;
                        end
                    endcase
                    if (idx != 2'd3) begin
                        idx = idx + 2'd1;
                    end
                    sda_low = 1'b1; // ack every byte
                end
            end else if (cnt == 4'd9) begin
                cnt = 4'd0;
                if (read_pending) begin
                    read_pending = 1'b0;
                    reading      = 1'b1;
                    tx           = mem[ptr];
                    sda_low      = ~tx[7];
                end else begin
                    if (reading) begin
                        reading = 1'b0;
                        ptr     = ptr + 11'd1;
                    end
                    sda_low = 1'b0;
                end
            end else if (reading && cnt >= 4'd1 && cnt <= 4'd7) begin
                sda_low = ~tx[3'(4'd7 - cnt)];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== dv/tb_eeprom.sv ====
module tb_eeprom import eeprom_pkg::*; ();

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    eeprom_req_t req;
    logic        sda_in;
    logic        busy;
    logic        ack;
    logic [7:0]  rdata;
    logic        scl;
    logic        sda_low;
    logic        model_low;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rng;
    logic [7:0]  shadow [0:2047];

    assign sda_in = ~(sda_low | model_low); // open-drain wired and

    eeprom_if_top eeprom_if_top_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .req     (req),
        .sda_in  (sda_in),
        .busy    (busy),
        .ack     (ack),
        .rdata   (rdata),
        .scl     (scl),
        .sda_low (sda_low)
    );

    eeprom_model model_i (
        .scl     (scl),
        .sda     (sda_in),
        .sda_low (model_low)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("[FAIL] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // returns on the negedge inside the ack cycle
    task automatic wait_ack(output logic [7:0] val);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        val  = 8'h00;
        while (!seen && n < 1000) begin
            @(negedge CLK);
            n++;
            if (ack) begin
                seen = 1'b1;
                val  = rdata;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: no ack within 1000 cycles, controller in state %s",
                     eeprom_if_top_i.u_ctrl.state.name());
        end
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
        logic [7:0] v;
        req = '{op: OP_WRITE, addr: a, wdata: d};
        wr  = 1'b1;
        @(negedge CLK);
        wr  = 1'b0;
        wait_ack(v);
        shadow[a] = d;
    endtask

    task automatic read_byte(input logic [10:0] a, output logic [7:0] v);
        req = '{op: OP_READ, addr: a, wdata: 8'h00};
        rd  = 1'b1;
        @(negedge CLK);
        rd  = 1'b0;
        wait_ack(v);
    endtask

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        if (scl !== 1'b1) report_value("scl", 32'(scl), 1);
        if (sda_low !== 1'b0) report_value("sda_low", 32'(sda_low), 0);
        if (busy !== 1'b0) report_value("busy", 32'(busy), 0);
        if (ack !== 1'b0) report_value("ack", 32'(ack), 0);
        if (rdata !== 8'h00) report_value("rdata", 32'(rdata), 0);
        end_test("reset", e0);
    endtask

    task automatic test_single_rw();
        int         e0;
        logic [7:0] v;
        e0 = errors;
        write_byte(11'h123, 8'h5a);
        read_byte(11'h123, v);
        if (v !== 8'h5a) report_value("rdata", 32'(v), 32'h5a);
        if (model_i.master_nack !== 1'b1)
            report_value("master_nack", 32'(model_i.master_nack), 1);
        end_test("single write and read", e0);
    endtask

    task automatic test_random_blocks();
        int          e0;
        logic [10:0] a [16];
        logic [7:0]  v;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            rng  = xorshift(rng);
            a[i] = {3'(i), rng[7:0]}; // every block twice
            write_byte(a[i], rng[15:8]);
            if (model_i.last_ctrl !== {4'b1010, a[i][10:8], 1'b0})
                report_value("ctrl_wr", 32'(model_i.last_ctrl),
                             32'({4'b1010, a[i][10:8], 1'b0}));
        end
        for (int i = 0; i < 16; i++) begin
            read_byte(a[i], v);
            if (v !== shadow[a[i]]) report_value("rdata", 32'(v), 32'(shadow[a[i]]));
            if (model_i.last_ctrl !== {4'b1010, a[i][10:8], 1'b1})
                report_value("ctrl_rd", 32'(model_i.last_ctrl),
                             32'({4'b1010, a[i][10:8], 1'b1}));
        end
        end_test("random blocks", e0);
    endtask

    task automatic test_bus_counts();
        int         e0;
        int         s0;
        int         p0;
        logic [7:0] v;
        e0 = errors;
        s0 = model_i.start_cnt;
        p0 = model_i.stop_cnt;
        write_byte(11'h42f, 8'hc3);
        if (model_i.start_cnt - s0 != 1) report_value("starts", model_i.start_cnt - s0, 1);
        if (model_i.stop_cnt - p0 != 1) report_value("stops", model_i.stop_cnt - p0, 1);
        s0 = model_i.start_cnt;
        p0 = model_i.stop_cnt;
        read_byte(11'h42f, v);
        if (model_i.start_cnt - s0 != 2) report_value("starts", model_i.start_cnt - s0, 2);
        if (model_i.stop_cnt - p0 != 1) report_value("stops", model_i.stop_cnt - p0, 1);
        end_test("start and stop counts", e0);
    endtask

    task automatic test_busy_strobe();
        int         e0;
        int         n;
        int         extra;
        logic [7:0] v;
        e0 = errors;
        req = '{op: OP_WRITE, addr: 11'h2b6, wdata: 8'h81};
        wr  = 1'b1;
        @(negedge CLK);
        wr  = 1'b0;
        n   = 0;
        while (!busy && n < 20) begin
            @(negedge CLK);
            n++;
        end
        if (!busy) begin
            errors++;
            $display("busy never rose after the write strobe");
        end
        req = '{op: OP_WRITE, addr: 11'h2b6, wdata: 8'h7e}; // must be dropped
        wr  = 1'b1;
        @(negedge CLK);
        wr  = 1'b0;
        wait_ack(v);
        shadow[11'h2b6] = 8'h81;
        extra = 0;
        repeat (400) begin
            @(negedge CLK);
            if (ack) extra++;
        end
        if (extra != 0) report_value("ack_count", extra + 1, 1);
        if (model_i.mem[11'h2b6] !== 8'h81)
            report_value("mem", 32'(model_i.mem[11'h2b6]), 32'h81);
        read_byte(11'h2b6, v);
        if (v !== 8'h81) report_value("rdata", 32'(v), 32'h81);
        end_test("strobe while busy", e0);
    endtask

    task automatic test_write_priority();
        int         e0;
        logic [7:0] v;
        e0 = errors;
        req = '{op: OP_READ, addr: 11'h6d1, wdata: 8'h3c};
        wr  = 1'b1;
        rd  = 1'b1;
        @(negedge CLK);
        wr  = 1'b0;
        rd  = 1'b0;
        wait_ack(v);
        shadow[11'h6d1] = 8'h3c;
        if (model_i.last_ctrl[0] !== 1'b0)
            report_value("ctrl_rw", 32'(model_i.last_ctrl[0]), 0);
        if (model_i.mem[11'h6d1] !== 8'h3c)
            report_value("mem", 32'(model_i.mem[11'h6d1]), 32'h3c);
        read_byte(11'h6d1, v);
        if (v !== 8'h3c) report_value("rdata", 32'(v), 32'h3c);
        end_test("write wins", e0);
    endtask

    initial begin
        logic [10:0] a;
        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        req          = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng          = 32'h8049b328;
        for (int i = 0; i < 2048; i++) begin
            a = 11'(i);
            shadow[i] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        test_reset_values();
        test_single_rw();
        test_random_blocks();
        test_bus_counts();
        test_busy_strobe();
        test_write_priority();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/eeprom_pkg.sv
src/bus_cond.sv
src/byte_tx.sv
src/byte_rx.sv
src/eeprom_ctrl.sv
src/eeprom_if_top.sv
dv/eeprom_model.sv
dv/tb_eeprom.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench, status follows the result line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_eeprom -o tb_eeprom \
    && ./obj_dir/tb_eeprom | tee /dev/stderr | grep -q "All checks passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
